// ==== list.f ====
common/game_pkg.sv
verilog/button_sync.sv
game_fsm/countdown_timer.sv
game_fsm/game_ctrl.sv
display/seg_scan.sv
display/matrix_show.sv
display/beep_gen.sv
verilog/game_top.sv
verif/tb_game_top.sv

// ==== verif/tb_game_top.sv ====
`timescale 1ns/1ps

module tb_game_top;

    localparam int TICK_DIV      = 20;
    localparam int COUNT_SECONDS = 3;
    localparam int SCAN_DIV      = 4;
    localparam int TONE_DIV      = 2;

    // memorize phase plus some slack for button and load latency
    localparam int PHASE_CYCLES = COUNT_SECONDS * TICK_DIV + 20;
    localparam int SCAN_WAIT    = 8 * SCAN_DIV * 2;
    localparam int BEEP_WINDOW  = 32;
    // one tone lasts a second tick, a correct guess toggles twice as often
    localparam int LOW_TOGGLES  = TICK_DIV / TONE_DIV;
    localparam int HIGH_TOGGLES = TICK_DIV / (TONE_DIV / 2);
    // rough length of each test in second ticks
    localparam int TEST_TICKS      = 6 + 5 + 6 + 5 + 18 + 9;
    localparam int WATCHDOG_CYCLES = TEST_TICKS * TICK_DIV * 2;

    logic        clk;
    logic        sw;
    logic        start;
    logic        next;
    logic [6:0]  guess;
    logic [15:0] led;
    logic [7:0]  seg;
    logic [7:0]  dig;
    logic [7:0]  row;
    logic [7:0]  colg;
    logic [7:0]  colr;
    logic        beep;

    int          errors = 0;
    int          checks = 0;
    int          level_model;
    logic [6:0]  target_model;
    logic [31:0] lcg_state;

    game_top #(
        .TICK_DIV      (TICK_DIV),
        .COUNT_SECONDS (COUNT_SECONDS),
        .SCAN_DIV      (SCAN_DIV),
        .TONE_DIV      (TONE_DIV)
    ) u_game_top
    (
        .clk   (clk),
        .sw    (sw),
        .start (start),
        .next  (next),
        .guess (guess),
        .led   (led),
        .seg   (seg),
        .dig   (dig),
        .row   (row),
        .colg  (colg),
        .colr  (colr),
        .beep  (beep)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // active low segments a..g in bits 0..6, dp in bit 7; -1 blank, -2 unknown
    function automatic int seg_to_digit(input logic [7:0] s);
        case (s)
            8'hff: return -1;
            8'hc0: return 0;
            8'hf9: return 1;
            8'ha4: return 2;
            8'hb0: return 3;
            8'h99: return 4;
            8'h92: return 5;
            8'h82: return 6;
            8'hf8: return 7;
            8'h80: return 8;
            8'h90: return 9;
            default: return -2;
        endcase
    endfunction

    task automatic check_led(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERROR %s: led expected %h actual %h", name, expected, actual);
        end
    endtask

    // zero expected toggles means the beeper must stay silent
    task automatic check_beep(input string name, input int expected, input int window);
        logic last;
        int   toggles;
        toggles = 0;
        @(negedge clk);
        last = beep;
        repeat (window)
        begin
            @(negedge clk);
            if (beep !== last)
                toggles++;
            last = beep;
        end
        checks++;
        if (toggles != expected)
        begin
            errors++;
            $display("ERROR %s: beep toggles expected %0d actual %0d",
                     name, expected, toggles);
        end
        else if (beep !== 1'b0)
        begin
            errors++;
            $display("%s: beep did not return to silence", name);
        end
    endtask

    task automatic check_seg_digit(input string name, input int pos, input int expected);
        int n;
        int actual;
        n = 0;
        @(negedge clk);
        while (dig !== ~(8'd1 << pos) && n < SCAN_WAIT)
        begin
            @(negedge clk);
            n++;
        end
        if (dig !== ~(8'd1 << pos))
        begin
            errors++;
            $display("%s: digit %0d was never selected by the scan", name, pos);
        end
        else
        begin
            actual = seg_to_digit(seg);
            checks++;
            if (actual != expected)
            begin
                errors++;
                $display("ERROR %s: digit %0d expected %0d actual %0d",
                         name, pos, expected, actual);
            end
        end
    endtask

    // pictures are green, the running seconds red, one row driven at a time
    task automatic check_matrix(input string name, input bit green);
        logic [7:0] other;
        int         bad_rows;
        bit         lit;
        other    = 8'h00;
        bad_rows = 0;
        lit      = 0;
        repeat (SCAN_WAIT)
        begin
            @(negedge clk);
            if (green)
            begin
                other = other | colr;
                lit   = lit | (colg != 8'h00);
            end
            else
            begin
                other = other | colg;
                lit   = lit | (colr != 8'h00);
            end
            if ($countones(row) < 7)
                bad_rows++;
        end
        checks++;
        if (other !== 8'h00)
        begin
            errors++;
            $display("ERROR %s: matrix off colour expected %h actual %h", name, 8'h00, other);
        end
        if (!lit)
        begin
            errors++;
            $display("%s: the matrix picture never lit", name);
        end
        if (bad_rows != 0)
        begin
            errors++;
            $display("%s: the matrix drove more than one row at once", name);
        end
    endtask

    task automatic wait_led(input string name, input bit lit, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (((led != 16'd0) != lit) && n < max_cycles)
        begin
            @(negedge clk);
            n++;
        end
        if ((led != 16'd0) != lit)
        begin
            errors++;
            if (lit)
                $display("%s: led never showed a target within %0d cycles", name, max_cycles);
            else
                $display("%s: led never went dark within %0d cycles", name, max_cycles);
        end
    endtask

    // target must fit in level + LEVEL_WIDTH_BASE bits and not be empty
    task automatic capture_target(input string name);
        logic [15:0] mask;
        mask = (16'd1 << (level_model + game_pkg::LEVEL_WIDTH_BASE)) - 16'd1;
        check_led(name, 16'd0, led & ~mask);
        checks++;
        if (led == 16'd0)
        begin
            errors++;
            $display("%s: led shows no target during the countdown", name);
        end
        target_model = led[6:0];
    endtask

    task automatic press_button(input bit is_start);
        @(negedge clk);
        if (is_start)
            start = 1'b1;
        else
            next = 1'b1;
        repeat (4) @(negedge clk);
        start = 1'b0;
        next  = 1'b0;
    endtask

    task automatic submit_guess(input logic [6:0] value);
        @(negedge clk);
        guess = value;
        press_button(1'b1);
    endtask

    task automatic test_reset();
        int p;
        check_led("reset", 16'd0, led);
        check_beep("reset", 0, 40);
        for (p = 0; p < 8; p++)
            check_seg_digit("reset", p, -1);
        check_matrix("reset", 1'b1);
    endtask

    task automatic test_first_level();
        press_button(1'b0);
        level_model = 1;
        wait_led("first_level", 1'b1, 20);
        capture_target("first_level");
        check_seg_digit("first_level", 0, level_model);
        wait_led("first_level", 1'b0, PHASE_CYCLES);
        // memorize time is over and the target stays hidden
        repeat (10)
        begin
            @(negedge clk);
            check_led("first_level", 16'd0, led);
        end
        check_seg_digit("first_level", 1, 0);
        check_matrix("first_level", 1'b0);
    endtask

    task automatic test_wrong_guess();
        logic [31:0] rnd;
        logic [6:0]  mask;
        logic [6:0]  offset;
        logic [6:0]  old_target;
        rnd    = lcg_next();
        mask   = 7'((1 << (level_model + game_pkg::LEVEL_WIDTH_BASE)) - 1);
        offset = rnd[22:16] & mask;
        if (offset == 7'd0)
            offset = 7'd1;
        old_target = target_model;
        submit_guess(old_target ^ offset);
        check_beep("wrong_guess", LOW_TOGGLES, BEEP_WINDOW);
        wait_led("wrong_guess", 1'b1, 20);
        check_led("wrong_guess", {9'd0, old_target}, led);
        check_seg_digit("wrong_guess", 0, level_model);
        wait_led("wrong_guess", 1'b0, PHASE_CYCLES);
    endtask

    task automatic test_early_start();
        press_button(1'b0);
        level_model = 1;
        wait_led("early_start", 1'b1, 20);
        capture_target("early_start");
        press_button(1'b1);
        check_beep("early_start", 0, 30);
        check_led("early_start", {9'd0, target_model}, led);
        wait_led("early_start", 1'b0, PHASE_CYCLES);
    endtask

    task automatic test_three_levels();
        int lvl;
        press_button(1'b0);
        level_model = 1;
        for (lvl = 1; lvl <= game_pkg::MAX_LEVEL; lvl++)
        begin
            wait_led("three_levels", 1'b1, 20);
            capture_target("three_levels");
            check_seg_digit("three_levels", 0, level_model);
            wait_led("three_levels", 1'b0, PHASE_CYCLES);
            submit_guess(target_model);
            check_beep("three_levels", HIGH_TOGGLES, BEEP_WINDOW);
            if (level_model < game_pkg::MAX_LEVEL)
                level_model++;
        end
        // victory, nothing more to memorize
        repeat (30)
        begin
            @(negedge clk);
            check_led("three_levels", 16'd0, led);
        end
        check_matrix("three_levels", 1'b1);
        press_button(1'b0);
        level_model = 1;
        wait_led("three_levels", 1'b1, 20);
        capture_target("three_levels");
        check_seg_digit("three_levels", 0, level_model);
        wait_led("three_levels", 1'b0, PHASE_CYCLES);
    endtask

    task automatic test_mid_restart();
        submit_guess(target_model);
        check_beep("mid_restart", HIGH_TOGGLES, BEEP_WINDOW);
        level_model = 2;
        wait_led("mid_restart", 1'b1, 20);
        capture_target("mid_restart");
        // still counting down at level 2
        press_button(1'b0);
        level_model = 1;
        repeat (3) @(negedge clk);
        capture_target("mid_restart");
        check_seg_digit("mid_restart", 0, level_model);
        wait_led("mid_restart", 1'b0, PHASE_CYCLES);
    endtask

    initial
    begin
        clk         = 1'b0;
        sw          = 1'b1;
        start       = 1'b0;
        next        = 1'b0;
        guess       = 7'd0;
        level_model = 1;
        lcg_state   = 32'd22;
        repeat (16) @(negedge clk);
        sw = 1'b0;

        test_reset();
        test_first_level();
        test_wrong_guess();
        test_early_start();
        test_three_levels();
        test_mid_restart();

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== verilog/game_top.sv ====
`timescale 1ns/1ps

module game_top
#(
    parameter int TICK_DIV      = 50_000_000,
    parameter int COUNT_SECONDS = 5,
    parameter int SCAN_DIV      = 50_000,
    parameter int TONE_DIV      = 25_000
)
(
    input  logic        clk,
    input  logic        sw,
    input  logic        start,
    input  logic        next,
    input  logic [6:0]  guess,
    output logic [15:0] led,
    output logic [7:0]  seg,
    output logic [7:0]  dig,
    output logic [7:0]  row,
    output logic [7:0]  colg,
    output logic [7:0]  colr,
    output logic        beep
);

    game_pkg::button_evt_t      evt;
    game_pkg::game_status_t     status;
    game_pkg::beep_evt_t        beep_evt;
    logic [game_pkg::SEC_W-1:0] seconds;
    logic                       cnt_load;
    logic                       cnt_over;

    // decode
    button_sync u_button_sync
    (
        .clk   (clk),
        .sw    (sw),
        .start (start),
        .next  (next),
        .evt   (evt)
    );

    // execute
    game_ctrl u_game_ctrl
    (
        .clk      (clk),
        .sw       (sw),
        .evt      (evt),
        .guess    (guess),
        .seconds  (seconds),
        .cnt_over (cnt_over),
        .cnt_load (cnt_load),
        .led      (led),
        .status   (status),
        .beep_evt (beep_evt)
    );

    countdown_timer #(.TICK_DIV(TICK_DIV), .COUNT_SECONDS(COUNT_SECONDS)) u_countdown_timer
    (
        .clk      (clk),
        .sw       (sw),
        .cnt_load (cnt_load),
        .seconds  (seconds),
        .cnt_over (cnt_over)
    );

    // result
    seg_scan #(.SCAN_DIV(SCAN_DIV)) u_seg_scan
    (
        .clk    (clk),
        .sw     (sw),
        .status (status),
        .seg    (seg),
        .dig    (dig)
    );

    matrix_show #(.SCAN_DIV(SCAN_DIV)) u_matrix_show
    (
        .clk    (clk),
        .sw     (sw),
        .status (status),
        .row    (row),
        .colg   (colg),
        .colr   (colr)
    );

    beep_gen #(.TICK_DIV(TICK_DIV), .TONE_DIV(TONE_DIV)) u_beep_gen
    (
        .clk      (clk),
        .sw       (sw),
        .beep_evt (beep_evt),
        .beep     (beep)
    );

endmodule

// ==== display/beep_gen.sv ====
`timescale 1ns/1ps

module beep_gen
#(
    parameter int TICK_DIV = 50_000_000,
    parameter int TONE_DIV = 25_000
)
(
    input  logic                clk,
    input  logic                sw,
    input  game_pkg::beep_evt_t beep_evt,
    output logic                beep
);

    localparam int DUR_W    = $clog2(TICK_DIV + 1);
    localparam int TONE_W   = $clog2(TONE_DIV + 1);
    localparam int HIGH_DIV = (TONE_DIV / 2 > 0) ? TONE_DIV / 2 : 1;

    logic [DUR_W-1:0]  dur;
    logic [TONE_W-1:0] tone_cnt;
    logic [TONE_W-1:0] tone_lim;
    logic              high;

    // correct guess plays an octave up
    assign tone_lim = high ? TONE_W'(HIGH_DIV - 1) : TONE_W'(TONE_DIV - 1);

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            dur      <= '0;
            tone_cnt <= '0;
            high     <= 1'b0;
            beep     <= 1'b0;
        end
        else if (beep_evt.trigger)
        begin
            dur      <= DUR_W'(TICK_DIV);
            tone_cnt <= '0;
            high     <= beep_evt.ok;
        end
        else if (dur != '0)
        begin
            dur <= dur - 1'b1;
            if (tone_cnt == tone_lim)
            begin
                tone_cnt <= '0;
                beep     <= ~beep;
            end
            else
            begin
                tone_cnt <= tone_cnt + 1'b1;
            end
        end
        else
        begin
            // silent between beeps
            tone_cnt <= '0;
            beep     <= 1'b0;
        end
    end

endmodule

// ==== display/matrix_show.sv ====
`timescale 1ns/1ps

module matrix_show
#(
    parameter int SCAN_DIV = 50_000
)
(
    input  logic                   clk,
    input  logic                   sw,
    input  game_pkg::game_status_t status,
    output logic [7:0]             row,
    output logic [7:0]             colg,
    output logic [7:0]             colr
);

    localparam int DIV_W = $clog2(SCAN_DIV + 1);
    // top row in the high byte
    localparam logic [63:0] GREET_ROM   = 64'h3c42_a581_a599_423c;
    localparam logic [63:0] VICTORY_ROM = 64'h0001_0204_8850_2000;

    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       cur_row;
    logic [2:0]       next_row;
    logic [7:0]       pattern;

    // 3x5 font, rows 1 to 5, centred in the 8 columns
    function automatic logic [7:0] digit_row(input logic [3:0] d, input logic [2:0] rr);
        logic [14:0] g;
        logic [2:0]  bits;
        case (d)
            4'd0: g = 15'b111_101_101_101_111;
            4'd1: g = 15'b010_110_010_010_111;
            4'd2: g = 15'b111_001_111_100_111;
            4'd3: g = 15'b111_001_111_001_111;
            4'd4: g = 15'b101_101_111_001_001;
            4'd5: g = 15'b111_100_111_001_111;
            4'd6: g = 15'b111_100_111_101_111;
            4'd7: g = 15'b111_001_001_001_001;
            4'd8: g = 15'b111_101_111_101_111;
            4'd9: g = 15'b111_101_111_001_111;
            default: g = 15'd0;
        endcase
        if (rr >= 3'd1 && rr <= 3'd5)
            bits = g[3 * (5 - int'(rr)) +: 3];
        else
            bits = 3'b000;
        return {2'b00, bits, 3'b000};
    endfunction

    assign next_row = cur_row + 3'd1;

    always_comb
    begin
        case (status.pic)
            game_pkg::PIC_GREET:   pattern = GREET_ROM[63 - 8 * int'(next_row) -: 8];
            game_pkg::PIC_VICTORY: pattern = VICTORY_ROM[63 - 8 * int'(next_row) -: 8];
            default:               pattern = digit_row(status.seconds, next_row);
        endcase
    end

    // row active low, columns active high
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            div_cnt <= '0;
            cur_row <= 3'd7;
            row     <= 8'hff;
            colg    <= 8'h00;
            colr    <= 8'h00;
        end
        else if (div_cnt == DIV_W'(SCAN_DIV - 1))
        begin
            div_cnt <= '0;
            cur_row <= next_row;
            row     <= ~(8'd1 << next_row);
            // pictures in green, the running seconds in red
            colg    <= (status.pic != game_pkg::PIC_DIGIT) ? pattern : 8'h00;
            colr    <= (status.pic == game_pkg::PIC_DIGIT) ? pattern : 8'h00;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// ==== display/seg_scan.sv ====
`timescale 1ns/1ps

module seg_scan
#(
    parameter int SCAN_DIV = 50_000
)
(
    input  logic                   clk,
    input  logic                   sw,
    input  game_pkg::game_status_t status,
    output logic [7:0]             seg,
    output logic [7:0]             dig
);

    localparam int DIV_W = $clog2(SCAN_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       pos;
    logic [3:0]       value;
    logic             blank;

    // active high pattern, bit 0 is segment a
    function automatic logic [6:0] seg_table(input logic [3:0] v);
        case (v)
            4'h0: return 7'h3f;
            4'h1: return 7'h06;
            4'h2: return 7'h5b;
            4'h3: return 7'h4f;
            4'h4: return 7'h66;
            4'h5: return 7'h6d;
            4'h6: return 7'h7d;
            4'h7: return 7'h07;
            4'h8: return 7'h7f;
            4'h9: return 7'h6f;
            // longer countdowns fall into hex letters
            4'ha: return 7'h77;
            4'hb: return 7'h7c;
            4'hc: return 7'h39;
            4'hd: return 7'h5e;
            4'he: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // pos starts at 7 so the first step lands on digit 0
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            div_cnt <= '0;
            pos     <= 3'd7;
            dig     <= 8'hff;
        end
        else if (div_cnt == DIV_W'(SCAN_DIV - 1))
        begin
            div_cnt <= '0;
            pos     <= pos + 3'd1;
            dig     <= ~(8'd1 << (pos + 3'd1));
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_comb
    begin
        value = 4'd0;
        blank = 1'b1;
        case (pos)
            3'd0:
            begin
                if (status.phase != game_pkg::GREET)
                begin
                    value = {2'b00, status.level};
                    blank = 1'b0;
                end
            end
            3'd1:
            begin
                if (status.phase == game_pkg::PLAY || status.phase == game_pkg::JUDGE)
                begin
                    value = status.seconds;
                    blank = 1'b0;
                end
            end
            default:
            begin
                blank = 1'b1;
            end
        endcase
    end

    // active low, dp kept dark
    assign seg = blank ? 8'hff : ~{1'b0, seg_table(value)};

endmodule

// ==== game_fsm/game_ctrl.sv ====
`timescale 1ns/1ps

module game_ctrl
(
    input  logic                       clk,
    input  logic                       sw,
    input  game_pkg::button_evt_t      evt,
    input  logic [6:0]                 guess,
    input  logic [game_pkg::SEC_W-1:0] seconds,
    input  logic                       cnt_over,
    output logic                       cnt_load,
    output logic [15:0]                led,
    output game_pkg::game_status_t     status,
    output game_pkg::beep_evt_t        beep_evt
);

    game_pkg::game_phase_e phase;
    game_pkg::picture_e    pic;
    logic [1:0]            level;
    logic [6:0]            target;
    logic [6:0]            lfsr;
    logic [6:0]            new_target;
    logic [2:0]            width;
    logic [7:0]            mask_w;
    logic [6:0]            mask;
    logic                  match;

    // x^7 + x^6 + 1, walks all 127 nonzero states
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            lfsr <= 7'h5a;
        else
            lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
    end

    // force a low bit so even a 5 bit target lights something
    assign new_target = {lfsr[6:1], lfsr[0] | (lfsr[4:0] == 5'd0)};

    assign width  = {1'b0, level} + 3'(game_pkg::LEVEL_WIDTH_BASE);
    assign mask_w = (8'd1 << width) - 8'd1;
    assign mask   = mask_w[6:0];
    assign match  = ((guess ^ target) & mask) == 7'd0;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            phase    <= game_pkg::GREET;
            level    <= 2'd1;
            target   <= 7'd0;
            cnt_load <= 1'b0;
            beep_evt <= '0;
        end
        else
        begin
            cnt_load <= 1'b0;
            beep_evt <= '0;
            case (phase)
                game_pkg::JUDGE:
                begin
                    // single cycle, next is not looked at here
                    beep_evt.trigger <= 1'b1;
                    beep_evt.ok      <= match;
                    if (!match)
                    begin
                        phase    <= game_pkg::PLAY;
                        cnt_load <= 1'b1;
                    end
                    else if (level == 2'(game_pkg::MAX_LEVEL))
                    begin
                        phase <= game_pkg::WIN;
                    end
                    else
                    begin
                        phase    <= game_pkg::PLAY;
                        level    <= level + 2'd1;
                        target   <= new_target;
                        cnt_load <= 1'b1;
                    end
                end
                default:
                begin
                    if (evt.next)
                    begin
                        phase    <= game_pkg::PLAY;
                        level    <= 2'd1;
                        target   <= new_target;
                        cnt_load <= 1'b1;
                    end
                    // cnt_over is stale in the cycle the timer reloads
                    else if (phase == game_pkg::PLAY && evt.start && cnt_over && !cnt_load)
                    begin
                        phase <= game_pkg::JUDGE;
                    end
                end
            endcase
        end
    end

    // target only visible while memorizing
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            led <= 16'd0;
        else if (phase == game_pkg::PLAY && !cnt_over)
            led <= {9'd0, target & mask};
        else
            led <= 16'd0;
    end

    always_comb
    begin
        case (phase)
            game_pkg::GREET: pic = game_pkg::PIC_GREET;
            game_pkg::WIN:   pic = game_pkg::PIC_VICTORY;
            default:         pic = game_pkg::PIC_DIGIT;
        endcase
    end

    assign status.phase   = phase;
    assign status.level   = level;
    assign status.seconds = seconds;
    assign status.pic     = pic;

endmodule

// ==== game_fsm/countdown_timer.sv ====
`timescale 1ns/1ps

module countdown_timer
#(
    parameter int TICK_DIV      = 50_000_000,
    parameter int COUNT_SECONDS = 5
)
(
    input  logic                       clk,
    input  logic                       sw,
    input  logic                       cnt_load,
    output logic [game_pkg::SEC_W-1:0] seconds,
    output logic                       cnt_over
);

    localparam int DIV_W = $clog2(TICK_DIV + 1);

    logic [DIV_W-1:0] div_cnt;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            div_cnt <= '0;
            seconds <= '0;
        end
        else if (cnt_load)
        begin
            div_cnt <= '0;
            seconds <= game_pkg::SEC_W'(COUNT_SECONDS);
        end
        else if (seconds != '0)
        begin
            if (div_cnt == DIV_W'(TICK_DIV - 1))
            begin
                div_cnt <= '0;
                seconds <= seconds - 1'b1;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // also high straight out of reset, the counter idles at zero
    assign cnt_over = (seconds == '0);

endmodule

// ==== verilog/button_sync.sv ====
`timescale 1ns/1ps

module button_sync
(
    input  logic                 clk,
    input  logic                 sw,
    input  logic                 start,
    input  logic                 next,
    output game_pkg::button_evt_t evt
);

    // bit 1 is start, bit 0 is next, matching the struct order
    logic [1:0] raw;
    logic [1:0] sync1;
    logic [1:0] sync2;
    logic [1:0] prev;

    assign raw = {start, next};

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            sync1 <= 2'b00;
            sync2 <= 2'b00;
            prev  <= 2'b00;
            evt   <= '0;
        end
        else
        begin
            sync1 <= raw;
            sync2 <= sync1;
            prev  <= sync2;
            // rising edge only, so a held button fires once
            evt   <= game_pkg::button_evt_t'(sync2 & ~prev);
        end
    end

endmodule

// ==== common/game_pkg.sv ====
package game_pkg;

    // target width is level + LEVEL_WIDTH_BASE
    localparam int LEVEL_WIDTH_BASE = 4;
    localparam int MAX_LEVEL = 3;
    localparam int SEC_W = 4;

    typedef enum logic [1:0]
    {
        GREET,
        PLAY,
        JUDGE,
        WIN
    } game_phase_e;

    typedef enum logic [1:0]
    {
        PIC_GREET,
        PIC_DIGIT,
        PIC_VICTORY
    } picture_e;

    // controller state as seen by the display side
    typedef struct packed
    {
        game_phase_e      phase;
        logic [1:0]       level;
        logic [SEC_W-1:0] seconds;
        picture_e         pic;
    } game_status_t;

    typedef struct packed
    {
        logic start;
        logic next;
    } button_evt_t;

    typedef struct packed
    {
        logic trigger;
        logic ok;
    } beep_evt_t;

endpackage
